// ==== verilog/clockLane_defs.svh ====
// Stage lengths in ppi cycles; T_PRE and T_POST must stay even and all values must fit CNT_W bits
`ifndef CLOCK_LANE_DEFS_SVH
`define CLOCK_LANE_DEFS_SVH

// Power-up and LP sequencing
`define CLK_LANE_T_INIT     20
`define CLK_LANE_T_LPX      4
`define CLK_LANE_T_PREPARE  3

// HS preamble
`define CLK_LANE_T_ZERO     8
`define CLK_LANE_T_PRE      4

// HS end of burst
`define CLK_LANE_T_POST     6
`define CLK_LANE_T_TRAIL    3
`define CLK_LANE_T_HS_EXIT  5

// ULPS exit
`define CLK_LANE_T_WAKEUP   30

// Stage counter width
`define CLK_LANE_CNT_W      6

`endif

// ==== verilog/lineStatePkg.sv ====
// Line levels of one differential clock lane; the off lane is driven as LP00, never left floating
package lineStatePkg;

    // Levels seen on the Dp/Dn pair
    // Lp values name Dp first, then Dn
    typedef enum logic [2:0]
    {
        Lp00 = 3'd0,
        Lp01 = 3'd1,
        Lp10 = 3'd2,
        Lp11 = 3'd3,
        Hs0  = 3'd4,
        Hs1  = 3'd5
    } lineState_t;

endpackage

// ==== verilog/laneCtrlPkg.sv ====
// Controller types of the clock lane; no HS idle and no error state exist in this controller
package laneCtrlPkg;

    // Request resolved from the PPI levels
    typedef enum logic [2:0]
    {
        CmdOff      = 3'd0,
        CmdNone     = 3'd1,
        CmdHs       = 3'd2,
        CmdUlps     = 3'd3,
        CmdUlpsExit = 3'd4
    } laneCmd_t;

    // Sequencer states, timed stages included
    typedef enum logic [3:0]
    {
        Off, Init, Stop,
        HsLpx, HsPrepare, HsZero, HsPre, HsTx, HsPost, HsTrail, HsExit,
        UlpsEntry, Ulps, UlpsWakeup
    } laneState_t;

endpackage

// ==== verilog/requestDecoder.sv ====
// Request levels are sampled on ppi with no synchronizer; HS wins over ULPS when both are raised
module requestDecoder
    import laneCtrlPkg::*;
(
    input  logic     ppi,
    input  logic     hs_clk,
    input  logic     enable,
    input  logic     txRequestHs,
    input  logic     txUlpsClk,
    input  logic     txUlpsExit,
    output laneCmd_t cmd
);

    laneCmd_t nextCmd;

    // Fixed priority, shutdown first
    always_comb
    begin
        if (!enable)
        begin
            nextCmd = CmdOff;
        end
        else if (txRequestHs)
        begin
            nextCmd = CmdHs;
        end
        else if (txUlpsClk && txUlpsExit)
        begin
            nextCmd = CmdUlpsExit;
        end
        else if (txUlpsClk)
        begin
            nextCmd = CmdUlps;
        end
        else
        begin
            nextCmd = CmdNone;
        end
    end

    // One register stage between the PPI pins and the sequencer
    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            cmd <= CmdOff;
        end
        else
        begin
            cmd <= nextCmd;
        end
    end

endmodule

// ==== verilog/laneSequencer.sv ====
// HsTx is left only after an even number of cycles, so an HS exit may take one extra cycle
`include "clockLane_defs.svh"

module laneSequencer
    import laneCtrlPkg::*;
(
    input  logic       ppi,
    input  logic       hs_clk,
    input  laneCmd_t   cmd,
    output laneState_t state
);

    localparam int CntW = `CLK_LANE_CNT_W;

    // Counter load values, a stage of N cycles counts N-1 down to 0
    localparam logic [CntW-1:0] LenInit    = CntW'(`CLK_LANE_T_INIT - 1);
    localparam logic [CntW-1:0] LenLpx     = CntW'(`CLK_LANE_T_LPX - 1);
    localparam logic [CntW-1:0] LenPrepare = CntW'(`CLK_LANE_T_PREPARE - 1);
    localparam logic [CntW-1:0] LenZero    = CntW'(`CLK_LANE_T_ZERO - 1);
    localparam logic [CntW-1:0] LenPre     = CntW'(`CLK_LANE_T_PRE - 1);
    localparam logic [CntW-1:0] LenPost    = CntW'(`CLK_LANE_T_POST - 1);
    localparam logic [CntW-1:0] LenTrail   = CntW'(`CLK_LANE_T_TRAIL - 1);
    localparam logic [CntW-1:0] LenHsExit  = CntW'(`CLK_LANE_T_HS_EXIT - 1);
    localparam logic [CntW-1:0] LenWakeup  = CntW'(`CLK_LANE_T_WAKEUP - 1);

    laneState_t      nextState;
    logic [CntW-1:0] cnt;
    logic [CntW-1:0] nextCnt;
    logic            expired;

    assign expired = (cnt == '0);

    always_comb
    begin
        nextState = state;
        // Count down and hold at zero once expired
        nextCnt   = expired ? cnt : cnt - 1'b1;

        case (state)
            Off:
            begin
                if (cmd != CmdOff)
                begin
                    nextState = Init;
                    nextCnt   = LenInit;
                end
            end
            Init:
            begin
                if (expired)
                begin
                    nextState = Stop;
                end
            end
            Stop:
            begin
                if (cmd == CmdHs)
                begin
                    nextState = HsLpx;
                    nextCnt   = LenLpx;
                end
                else if (cmd == CmdUlps)
                begin
                    nextState = UlpsEntry;
                    nextCnt   = LenLpx;
                end
            end
            HsLpx:
            begin
                if (expired)
                begin
                    nextState = HsPrepare;
                    nextCnt   = LenPrepare;
                end
            end
            HsPrepare:
            begin
                if (expired)
                begin
                    nextState = HsZero;
                    nextCnt   = LenZero;
                end
            end
            HsZero:
            begin
                if (expired)
                begin
                    nextState = HsPre;
                    nextCnt   = LenPre;
                end
            end
            HsPre:
            begin
                if (expired)
                begin
                    nextState = HsTx;
                    nextCnt   = '0;
                end
            end
            HsTx:
            begin
                // Bit 0 tracks the HS phase, 1 means this cycle shows Hs0
                nextCnt = cnt ^ CntW'(1);
                if (cmd != CmdHs && cnt[0])
                begin
                    nextState = HsPost;
                    nextCnt   = LenPost;
                end
            end
            HsPost:
            begin
                if (expired)
                begin
                    nextState = HsTrail;
                    nextCnt   = LenTrail;
                end
            end
            HsTrail:
            begin
                if (expired)
                begin
                    nextState = HsExit;
                    nextCnt   = LenHsExit;
                end
            end
            HsExit:
            begin
                if (expired)
                begin
                    nextState = Stop;
                end
            end
            UlpsEntry:
            begin
                if (expired)
                begin
                    nextState = Ulps;
                end
            end
            Ulps:
            begin
                if (cmd == CmdUlpsExit)
                begin
                    nextState = UlpsWakeup;
                    nextCnt   = LenWakeup;
                end
            end
            UlpsWakeup:
            begin
                // Minimum wakeup time, then wait for the ULPS request to go
                if (expired && cmd == CmdNone)
                begin
                    nextState = Stop;
                end
            end
            default:
            begin
                nextState = Off;
                nextCnt   = '0;
            end
        endcase

        // Shutdown overrides any stage
        if (cmd == CmdOff)
        begin
            nextState = Off;
            nextCnt   = '0;
        end
    end

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            state <= Off;
            cnt   <= '0;
        end
        else
        begin
            state <= nextState;
            cnt   <= nextCnt;
        end
    end

endmodule

// ==== verilog/lineDriver.sv ====
// Outputs follow the sequencer state one ppi cycle late; the HS clock toggles once per ppi cycle
module lineDriver
    import lineStatePkg::*;
    import laneCtrlPkg::*;
(
    input  logic       ppi,
    input  logic       hs_clk,
    input  laneState_t state,
    output lineState_t line,
    output logic       stopstate,
    output logic       txReadyHs,
    output logic       ulpsActiveNot
);

    lineState_t nextLine;
    logic       toggling;
    // High when the next toggle cycle shows Hs1
    logic       hsPhase;

    assign toggling = (state == HsPre) || (state == HsTx) || (state == HsPost);

    always_comb
    begin
        case (state)
            Init, Stop, HsExit:    nextLine = Lp11;
            HsLpx:                 nextLine = Lp01;
            HsZero, HsTrail:       nextLine = Hs0;
            HsPre, HsTx, HsPost:   nextLine = hsPhase ? Hs1 : Hs0;
            UlpsEntry, UlpsWakeup: nextLine = Lp10;
            default:               nextLine = Lp00;
        endcase
    end

    // Phase is parked at Hs1 outside the toggle states, so HsPre always starts high
    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            hsPhase <= 1'b1;
        end
        else
        begin
            hsPhase <= toggling ? ~hsPhase : 1'b1;
        end
    end

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            line          <= Lp00;
            stopstate     <= 1'b0;
            txReadyHs     <= 1'b0;
            ulpsActiveNot <= 1'b1;
        end
        else
        begin
            line          <= nextLine;
            stopstate     <= (state == Stop);
            txReadyHs     <= (state == HsTx);
            ulpsActiveNot <= (state != Ulps);
        end
    end

endmodule

// ==== verilog/clockLaneTx.sv ====
// Master clock lane, PPI levels in and line level out with three ppi cycles of latency
module clockLaneTx
    import lineStatePkg::*;
    import laneCtrlPkg::*;
(
    input  logic       ppi,
    input  logic       hs_clk,
    input  logic       enable,
    input  logic       txRequestHs,
    input  logic       txUlpsClk,
    input  logic       txUlpsExit,
    output lineState_t line,
    output logic       stopstate,
    output logic       txReadyHs,
    output logic       ulpsActiveNot
);

    laneCmd_t   cmd;
    laneState_t state;

    requestDecoder decoder (
        .ppi         (ppi),
        .hs_clk      (hs_clk),
        .enable      (enable),
        .txRequestHs (txRequestHs),
        .txUlpsClk   (txUlpsClk),
        .txUlpsExit  (txUlpsExit),
        .cmd         (cmd)
    );

    laneSequencer sequencer (
        .ppi    (ppi),
        .hs_clk (hs_clk),
        .cmd    (cmd),
        .state  (state)
    );

    lineDriver driver (
        .ppi           (ppi),
        .hs_clk        (hs_clk),
        .state         (state),
        .line          (line),
        .stopstate     (stopstate),
        .txReadyHs     (txReadyHs),
        .ulpsActiveNot (ulpsActiveNot)
    );

endmodule

// ==== testbench/clockLaneTb.sv ====
// Inputs change only in steady lane states; an odd HS burst holds HsTx for one more cycle
`include "clockLane_defs.svh"

module clockLaneTb
    import lineStatePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // Stage kinds of the reference model
    localparam int KOff    = 0;
    localparam int KLp11   = 1;
    localparam int KStop   = 2;
    localparam int KLp01   = 3;
    localparam int KLp00   = 4;
    localparam int KHs0    = 5;
    localparam int KToggle = 6;
    localparam int KReady  = 7;
    localparam int KLp10   = 8;
    localparam int KUlps   = 9;

    localparam int PreambleLen = `CLK_LANE_T_LPX + `CLK_LANE_T_PREPARE + `CLK_LANE_T_ZERO
                                 + `CLK_LANE_T_PRE;

    typedef struct packed
    {
        lineState_t line;
        logic       stop;
        logic       ready;
        logic       ulpsN;
    } outVal_t;

    typedef struct packed
    {
        int kind;
        int len;
    } stage_t;

    logic       ppi;
    logic       hs_clk;
    logic       enable;
    logic       txRequestHs;
    logic       txUlpsClk;
    logic       txUlpsExit;
    lineState_t line;
    logic       stopstate;
    logic       txReadyHs;
    logic       ulpsActiveNot;

    outVal_t    expQ[$];
    stage_t     stageQ[$];
    outVal_t    want;
    lineState_t wantLine;
    logic       togglePhase;
    int         errors;
    int         checks;
    int         tests;
    int         testErrors;
    int         cycles;
    int         cycleLimit;
    int         burstLen;
    int         cutLen;
    int         ulpsHold;

    clockLaneTx i_dut (
        .ppi           (ppi),
        .hs_clk        (hs_clk),
        .enable        (enable),
        .txRequestHs   (txRequestHs),
        .txUlpsClk     (txUlpsClk),
        .txUlpsExit    (txUlpsExit),
        .line          (line),
        .stopstate     (stopstate),
        .txReadyHs     (txReadyHs),
        .ulpsActiveNot (ulpsActiveNot)
    );

    always #20 ppi = ~ppi;

    // Expands the queued stages into one expected output word per ppi cycle
    function automatic void expectedFromStages();
        outVal_t v;
        stage_t  s;
        while (stageQ.size() > 0)
        begin
            s = stageQ.pop_front();
            for (int i = 0; i < s.len; i++)
            begin
                v.line  = Lp00;
                v.stop  = 1'b0;
                v.ready = 1'b0;
                v.ulpsN = 1'b1;
                // HS clock restarts at Hs1 after any stage that does not toggle
                if (s.kind != KToggle && s.kind != KReady)
                begin
                    togglePhase = 1'b1;
                end
                case (s.kind)
                    KLp11:   v.line = Lp11;
                    KStop:
                    begin
                        v.line = Lp11;
                        v.stop = 1'b1;
                    end
                    KLp01:   v.line = Lp01;
                    KHs0:    v.line = Hs0;
                    KToggle, KReady:
                    begin
                        v.line      = togglePhase ? Hs1 : Hs0;
                        v.ready     = (s.kind == KReady);
                        togglePhase = ~togglePhase;
                    end
                    KLp10:   v.line = Lp10;
                    KUlps:   v.ulpsN = 1'b0;
                    default: v.line = Lp00;
                endcase
                expQ.push_back(v);
            end
        end
    endfunction

    task automatic addStage(input int kind, input int len);
        stage_t s;
        s.kind = kind;
        s.len  = len;
        stageQ.push_back(s);
    endtask

    task automatic addPreamble();
        addStage(KLp01, `CLK_LANE_T_LPX);
        addStage(KLp00, `CLK_LANE_T_PREPARE);
        addStage(KHs0, `CLK_LANE_T_ZERO);
        addStage(KToggle, `CLK_LANE_T_PRE);
    endtask

    // Returns with three expected cycles still queued to cover the input to output latency
    task automatic runStages();
        int n;
        expectedFromStages();
        n = expQ.size() - 3;
        repeat (n) @(posedge ppi);
        #2;
    endtask

    task automatic endTest(input string name);
        tests++;
        $display("test %0d %s: %0d mismatches", tests, name, errors - testErrors);
        testErrors = errors;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge ppi)
    begin
        if (expQ.size() > 0)
        begin
            want     = expQ.pop_front();
            wantLine = want.line;
            checks++;
            if (line !== wantLine)
            begin
                errors++;
                $display("mismatch at %0t: line expected %s got %s",
                         $time, wantLine.name(), line.name());
            end
            if (stopstate !== want.stop)
            begin
                errors++;
                $display("mismatch at %0t: stopstate expected %b got %b",
                         $time, want.stop, stopstate);
            end
            if (txReadyHs !== want.ready)
            begin
                errors++;
                $display("mismatch at %0t: txReadyHs expected %b got %b",
                         $time, want.ready, txReadyHs);
            end
            if (ulpsActiveNot !== want.ulpsN)
            begin
                errors++;
                $display("mismatch at %0t: ulpsActiveNot expected %b got %b",
                         $time, want.ulpsN, ulpsActiveNot);
            end
        end
    end

    always @(posedge ppi)
    begin
        cycles++;
        if (cycles > cycleLimit)
        begin
            $display("Timeout: the run went past %0d ppi cycles", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    initial
    begin
        ppi         = 1'b0;
        hs_clk      = 1'b0;
        enable      = 1'b0;
        txRequestHs = 1'b0;
        txUlpsClk   = 1'b0;
        txUlpsExit  = 1'b0;
        togglePhase = 1'b1;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        testErrors  = 0;
        cycles      = 0;
        void'($urandom(89));
        burstLen = 10 + $urandom % 31;
        cutLen   = 10 + $urandom % 31;
        ulpsHold = 5 + $urandom % 16;
        cycleLimit = 5 + 13 + 2 * (`CLK_LANE_T_INIT + 6) + 2 * PreambleLen + burstLen + 1
                     + cutLen + `CLK_LANE_T_POST + `CLK_LANE_T_TRAIL + `CLK_LANE_T_HS_EXIT + 6
                     + `CLK_LANE_T_LPX + ulpsHold + `CLK_LANE_T_WAKEUP + 6 + 8 + 200;

        repeat (5) @(posedge ppi);
        #2;
        hs_clk = 1'b1;

        addStage(KOff, 13);
        runStages();
        endTest("off after reset");

        enable = 1'b1;
        addStage(KLp11, `CLK_LANE_T_INIT);
        addStage(KStop, 6);
        runStages();
        endTest("init to stop");

        txRequestHs = 1'b1;
        addPreamble();
        addStage(KReady, burstLen);
        runStages();
        endTest("hs entry and burst");

        txRequestHs = 1'b0;
        // Post must start on Hs1 to end on Hs0, so an odd burst keeps HsTx one more cycle
        if (burstLen % 2 == 1)
        begin
            addStage(KReady, 1);
        end
        addStage(KToggle, `CLK_LANE_T_POST);
        addStage(KHs0, `CLK_LANE_T_TRAIL);
        addStage(KLp11, `CLK_LANE_T_HS_EXIT);
        addStage(KStop, 6);
        runStages();
        endTest("hs exit");

        txUlpsClk = 1'b1;
        addStage(KLp10, `CLK_LANE_T_LPX);
        addStage(KUlps, ulpsHold);
        runStages();
        txUlpsExit = 1'b1;
        addStage(KLp10, `CLK_LANE_T_WAKEUP);
        runStages();
        txUlpsClk  = 1'b0;
        txUlpsExit = 1'b0;
        addStage(KStop, 6);
        runStages();
        endTest("ulps entry and exit");

        // Shutdown in the middle of a burst, then a fresh start
        txRequestHs = 1'b1;
        addPreamble();
        addStage(KReady, cutLen);
        runStages();
        enable      = 1'b0;
        txRequestHs = 1'b0;
        addStage(KOff, 8);
        runStages();
        enable = 1'b1;
        addStage(KLp11, `CLK_LANE_T_INIT);
        addStage(KStop, 6);
        runStages();
        repeat (3) @(posedge ppi);
        #2;
        endTest("shutdown during hs and restart");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
        begin
            $display("Finished with no errors");
        end
        else
        begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/lineStatePkg.sv
verilog/laneCtrlPkg.sv
verilog/requestDecoder.sv
verilog/laneSequencer.sv
verilog/lineDriver.sv
verilog/clockLaneTx.sv
testbench/clockLaneTb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = clockLaneTb
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log
FAILMSG   = Finished with errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)

run: build
	./$(OBJDIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
